// ==== hw/data_regs.sv ====
// bypass, idcode and dtmcs data registers of the tap, with the dtmcs reset pulses
`timescale 1ns/1ps

`include "jtag_tap_defines.svh"

module data_regs (
    input  logic                        jtag_tck_i,
    input  logic                        jtag_trstn_i,
    input  logic                        jtag_tdi_i,
    input  logic                        capture_dr_i,
    input  logic                        shift_dr_i,
    input  logic                        update_dr_i,
    input  logic                        sel_bypass_i,
    input  logic                        sel_idcode_i,
    input  logic                        sel_dtmcs_i,
    input  jtag_tap_pkg::dtmcs_version_t dtmcs_version_i,
    input  jtag_tap_pkg::dtmcs_abits_t   dtmcs_abits_i,
    input  jtag_tap_pkg::dtmcs_dmistat_t dtmcs_dmistat_i,
    input  jtag_tap_pkg::dtmcs_idle_t    dtmcs_idle_i,
    output logic                        dr_tdo_o,
    output logic                        hold_tdo_o,
    output logic                        dtmcs_dmireset_o,
    output logic                        dtmcs_dmihardreset_o
);
    import jtag_tap_pkg::*;

    logic     bypass_q;
    dr_word_t idcode_q;
    dr_word_t dtmcs_q;
    dr_word_t idcode_word;
    dr_word_t dtmcs_word;

    // capture values
    assign idcode_word = {`JTAG_IDCODE_VERSION, `JTAG_IDCODE_PART, `JTAG_IDCODE_MANUF, 1'b1};
    assign dtmcs_word  = {17'h0, dtmcs_idle_i, dtmcs_dmistat_i, dtmcs_abits_i, dtmcs_version_i};

    ////////////////////
    // bypass
    ////////////////////
    always_ff @(posedge jtag_tck_i or negedge jtag_trstn_i) begin
        if (!jtag_trstn_i) begin
            bypass_q <= 1'b0;
        end else if (sel_bypass_i && shift_dr_i) begin
            bypass_q <= jtag_tdi_i;
        end else if (sel_bypass_i && capture_dr_i) begin
            bypass_q <= 1'b0;
        end
    end

    ////////////////////
    // idcode
    ////////////////////
    always_ff @(posedge jtag_tck_i or negedge jtag_trstn_i) begin
        if (!jtag_trstn_i) begin
            idcode_q <= '0;
        end else if (sel_idcode_i && shift_dr_i) begin
            idcode_q <= {jtag_tdi_i, idcode_q[`JTAG_DR_WIDTH-1:1]};
        end else if (sel_idcode_i && capture_dr_i) begin
            idcode_q <= idcode_word;
        end
    end

    ////////////////////
    // dtmcs
    ////////////////////
    always_ff @(posedge jtag_tck_i or negedge jtag_trstn_i) begin
        if (!jtag_trstn_i) begin
            dtmcs_q <= '0;
        end else if (sel_dtmcs_i && shift_dr_i) begin
            dtmcs_q <= {jtag_tdi_i, dtmcs_q[`JTAG_DR_WIDTH-1:1]};
        end else if (sel_dtmcs_i && capture_dr_i) begin
            dtmcs_q <= dtmcs_word;
        end
    end

    // one update-dr cycle per request, straight from the shifted bits
    assign dtmcs_dmireset_o     = sel_dtmcs_i && update_dr_i
                               && dtmcs_q[`JTAG_DTMCS_DMIRESET_BIT];
    assign dtmcs_dmihardreset_o = sel_dtmcs_i && update_dr_i
                               && dtmcs_q[`JTAG_DTMCS_HARDRESET_BIT];

    // serial out of the selected register
    always_comb begin
        if (sel_dtmcs_i) begin
            dr_tdo_o = dtmcs_q[0];
        end else if (sel_idcode_i) begin
            dr_tdo_o = idcode_q[0];
        end else if (sel_bypass_i) begin
            dr_tdo_o = bypass_q;
        end else begin
            dr_tdo_o = 1'b0;
        end
    end

    // no register behind the current instruction
    assign hold_tdo_o = !(sel_bypass_i || sel_idcode_i || sel_dtmcs_i);

endmodule

// ==== hw/instr_reg.sv ====
// instruction shift and update register of the tap, decoded into the data register selects
`timescale 1ns/1ps

`include "jtag_tap_defines.svh"

module instr_reg (
    input  logic jtag_tck_i,
    input  logic jtag_trstn_i,
    input  logic jtag_tdi_i,
    input  logic capture_ir_i,
    input  logic shift_ir_i,
    input  logic update_ir_i,
    output logic ir_tdo_o,
    output logic sel_bypass_o,
    output logic sel_idcode_o,
    output logic sel_dtmcs_o
);
    import jtag_tap_pkg::*;

    ir_t ir_shift_q;
    ir_t ir_instr_q;

    ////////////////////
    // shift stage
    ////////////////////
    // tdi enters at the msb, lsb goes out on tdo
    always_ff @(posedge jtag_tck_i or negedge jtag_trstn_i) begin
        if (!jtag_trstn_i) begin
            ir_shift_q <= '0;
        end else if (shift_ir_i) begin
            ir_shift_q <= {jtag_tdi_i, ir_shift_q[`JTAG_IR_WIDTH-1:1]};
        end else if (capture_ir_i) begin
            ir_shift_q <= `JTAG_IR_CAPTURE;
        end
    end

    assign ir_tdo_o = ir_shift_q[0];

    ////////////////////
    // update stage
    ////////////////////
    // zero after reset, so bypass is the active instruction
    always_ff @(posedge jtag_tck_i or negedge jtag_trstn_i) begin
        if (!jtag_trstn_i) begin
            ir_instr_q <= '0;
        end else if (update_ir_i) begin
            ir_instr_q <= ir_shift_q;
        end
    end

    // decoder, unknown codes select nothing
    assign sel_bypass_o = (ir_instr_q == `JTAG_INSTR_BYPASS0)
                       || (ir_instr_q == `JTAG_INSTR_BYPASS1);
    assign sel_idcode_o = (ir_instr_q == `JTAG_INSTR_IDCODE);
    assign sel_dtmcs_o  = (ir_instr_q == `JTAG_INSTR_DTMCS);

endmodule

// ==== hw/jtag_tap_defines.svh ====
// widths, instruction codes and idcode/dtmcs constants, included by the package and the tap modules
`ifndef JTAG_TAP_DEFINES_SVH
`define JTAG_TAP_DEFINES_SVH

////////////////////
// register widths
////////////////////
`define JTAG_IR_WIDTH 5
`define JTAG_DR_WIDTH 32

// loaded into the instruction shift register in capture-ir
`define JTAG_IR_CAPTURE 5'b00001

////////////////////
// instruction codes
////////////////////
`define JTAG_INSTR_BYPASS0 5'h00
`define JTAG_INSTR_BYPASS1 5'h1f
`define JTAG_INSTR_IDCODE  5'h01
`define JTAG_INSTR_DTMCS   5'h10

// idcode fields, bit 0 of the word is always 1
`define JTAG_IDCODE_VERSION 4'h0
`define JTAG_IDCODE_PART    16'h0001
`define JTAG_IDCODE_MANUF   11'h012

// dtmcs write bits that produce the reset pulses
`define JTAG_DTMCS_DMIRESET_BIT  16
`define JTAG_DTMCS_HARDRESET_BIT 17

`endif

// ==== hw/jtag_tap_pkg.sv ====
// shared types of the jtag tap, imported by the modules that need a state or vector type
package jtag_tap_pkg;

    `include "jtag_tap_defines.svh"

    // tap controller states, ieee 1149.1 order
    typedef enum logic [3:0] {
        TAP_TEST_LOGIC_RESET = 4'h0,
        TAP_RUN_TEST_IDLE    = 4'h1,
        TAP_SELECT_DR_SCAN   = 4'h2,
        TAP_CAPTURE_DR       = 4'h3,
        TAP_SHIFT_DR         = 4'h4,
        TAP_EXIT1_DR         = 4'h5,
        TAP_PAUSE_DR         = 4'h6,
        TAP_EXIT2_DR         = 4'h7,
        TAP_UPDATE_DR        = 4'h8,
        TAP_SELECT_IR_SCAN   = 4'h9,
        TAP_CAPTURE_IR       = 4'ha,
        TAP_SHIFT_IR         = 4'hb,
        TAP_EXIT1_IR         = 4'hc,
        TAP_PAUSE_IR         = 4'hd,
        TAP_EXIT2_IR         = 4'he,
        TAP_UPDATE_IR        = 4'hf
    } tap_state_e;

    // instruction and data register words
    typedef logic [`JTAG_IR_WIDTH-1:0] ir_t;
    typedef logic [`JTAG_DR_WIDTH-1:0] dr_word_t;

    // dtmcs status fields from the debug module side
    typedef logic [3:0] dtmcs_version_t;
    typedef logic [5:0] dtmcs_abits_t;
    typedef logic [1:0] dtmcs_dmistat_t;
    typedef logic [2:0] dtmcs_idle_t;

endpackage

// ==== hw/jtag_tap_top.sv ====
// top of the jtag tap for the risc-v debug transport, connects controller, registers and tdo
`timescale 1ns/1ps

module jtag_tap_top (
    input  logic                        jtag_tck_i,
    input  logic                        jtag_trstn_i,
    input  logic                        jtag_tms_i,
    input  logic                        jtag_tdi_i,
    input  jtag_tap_pkg::dtmcs_version_t dtmcs_version_i,
    input  jtag_tap_pkg::dtmcs_abits_t   dtmcs_abits_i,
    input  jtag_tap_pkg::dtmcs_dmistat_t dtmcs_dmistat_i,
    input  jtag_tap_pkg::dtmcs_idle_t    dtmcs_idle_i,
    output logic                        jtag_tdo_o,
    output logic                        jtag_tdo_enable_o,
    output logic                        dtmcs_dmireset_o,
    output logic                        dtmcs_dmihardreset_o
);

    // controller strobes
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic ir_path;
    logic shift_any;

    // instruction decode and serial outputs
    logic sel_bypass;
    logic sel_idcode;
    logic sel_dtmcs;
    logic ir_tdo;
    logic dr_tdo;
    logic hold_tdo;

    ////////////////////
    // tap controller
    ////////////////////
    tap_fsm u_tap_fsm (
        .jtag_tck_i   (jtag_tck_i),
        .jtag_trstn_i (jtag_trstn_i),
        .jtag_tms_i   (jtag_tms_i),
        .capture_ir_o (capture_ir),
        .shift_ir_o   (shift_ir),
        .update_ir_o  (update_ir),
        .capture_dr_o (capture_dr),
        .shift_dr_o   (shift_dr),
        .update_dr_o  (update_dr),
        .ir_path_o    (ir_path),
        .shift_any_o  (shift_any)
    );

    // instruction path
    instr_reg u_instr_reg (
        .jtag_tck_i   (jtag_tck_i),
        .jtag_trstn_i (jtag_trstn_i),
        .jtag_tdi_i   (jtag_tdi_i),
        .capture_ir_i (capture_ir),
        .shift_ir_i   (shift_ir),
        .update_ir_i  (update_ir),
        .ir_tdo_o     (ir_tdo),
        .sel_bypass_o (sel_bypass),
        .sel_idcode_o (sel_idcode),
        .sel_dtmcs_o  (sel_dtmcs)
    );

    // data register path
    data_regs u_data_regs (
        .jtag_tck_i           (jtag_tck_i),
        .jtag_trstn_i         (jtag_trstn_i),
        .jtag_tdi_i           (jtag_tdi_i),
        .capture_dr_i         (capture_dr),
        .shift_dr_i           (shift_dr),
        .update_dr_i          (update_dr),
        .sel_bypass_i         (sel_bypass),
        .sel_idcode_i         (sel_idcode),
        .sel_dtmcs_i          (sel_dtmcs),
        .dtmcs_version_i      (dtmcs_version_i),
        .dtmcs_abits_i        (dtmcs_abits_i),
        .dtmcs_dmistat_i      (dtmcs_dmistat_i),
        .dtmcs_idle_i         (dtmcs_idle_i),
        .dr_tdo_o             (dr_tdo),
        .hold_tdo_o           (hold_tdo),
        .dtmcs_dmireset_o     (dtmcs_dmireset_o),
        .dtmcs_dmihardreset_o (dtmcs_dmihardreset_o)
    );

    ////////////////////
    // tdo stage
    ////////////////////
    tdo_out u_tdo_out (
        .jtag_tck_i        (jtag_tck_i),
        .jtag_trstn_i      (jtag_trstn_i),
        .ir_path_i         (ir_path),
        .shift_any_i       (shift_any),
        .ir_tdo_i          (ir_tdo),
        .dr_tdo_i          (dr_tdo),
        .hold_tdo_i        (hold_tdo),
        .jtag_tdo_o        (jtag_tdo_o),
        .jtag_tdo_enable_o (jtag_tdo_enable_o)
    );

endmodule

// ==== hw/tap_fsm.sv ====
// tap controller state machine, steps on tms and decodes the ir/dr control strobes
`timescale 1ns/1ps

module tap_fsm (
    input  logic jtag_tck_i,
    input  logic jtag_trstn_i,
    input  logic jtag_tms_i,
    output logic capture_ir_o,
    output logic shift_ir_o,
    output logic update_ir_o,
    output logic capture_dr_o,
    output logic shift_dr_o,
    output logic update_dr_o,
    output logic ir_path_o,
    output logic shift_any_o
);
    import jtag_tap_pkg::*;

    tap_state_e state_q;
    tap_state_e state_d;

    ////////////////////
    // state register
    ////////////////////
    always_ff @(posedge jtag_tck_i or negedge jtag_trstn_i) begin
        if (!jtag_trstn_i) begin
            state_q <= TAP_TEST_LOGIC_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // standard tms transition table
    always_comb begin
        case (state_q)
            TAP_TEST_LOGIC_RESET: state_d = jtag_tms_i ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
            TAP_RUN_TEST_IDLE:    state_d = jtag_tms_i ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_DR_SCAN:   state_d = jtag_tms_i ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR:       state_d = jtag_tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR:         state_d = jtag_tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR:         state_d = jtag_tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:         state_d = jtag_tms_i ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR:         state_d = jtag_tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:        state_d = jtag_tms_i ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
            TAP_SELECT_IR_SCAN:   state_d = jtag_tms_i ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR:       state_d = jtag_tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR:         state_d = jtag_tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR:         state_d = jtag_tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:         state_d = jtag_tms_i ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR:         state_d = jtag_tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:        state_d = jtag_tms_i ? TAP_SELECT_IR_SCAN : TAP_RUN_TEST_IDLE;
            default:              state_d = TAP_TEST_LOGIC_RESET;
        endcase
    end

    ////////////////////
    // control strobes
    ////////////////////
    assign capture_ir_o = (state_q == TAP_CAPTURE_IR);
    assign shift_ir_o   = (state_q == TAP_SHIFT_IR);
    assign update_ir_o  = (state_q == TAP_UPDATE_IR);
    assign capture_dr_o = (state_q == TAP_CAPTURE_DR);
    assign shift_dr_o   = (state_q == TAP_SHIFT_DR);
    assign update_dr_o  = (state_q == TAP_UPDATE_DR);

    // capture-ir up to update-ir, tdo follows the instruction register
    assign ir_path_o = (state_q == TAP_CAPTURE_IR) || (state_q == TAP_SHIFT_IR)
                    || (state_q == TAP_EXIT1_IR)   || (state_q == TAP_PAUSE_IR)
                    || (state_q == TAP_EXIT2_IR)   || (state_q == TAP_UPDATE_IR);

    assign shift_any_o = (state_q == TAP_SHIFT_IR) || (state_q == TAP_SHIFT_DR);

endmodule

// ==== hw/tdo_out.sv ====
// tdo output stage of the tap, updated on the falling edge of tck
`timescale 1ns/1ps

module tdo_out (
    input  logic jtag_tck_i,
    input  logic jtag_trstn_i,
    input  logic ir_path_i,
    input  logic shift_any_i,
    input  logic ir_tdo_i,
    input  logic dr_tdo_i,
    input  logic hold_tdo_i,
    output logic jtag_tdo_o,
    output logic jtag_tdo_enable_o
);

    logic tdo_d;

    // ir path first, then the selected data register
    always_comb begin
        if (ir_path_i) begin
            tdo_d = ir_tdo_i;
        end else if (hold_tdo_i) begin
            tdo_d = jtag_tdo_o;
        end else begin
            tdo_d = dr_tdo_i;
        end
    end

    ////////////////////
    // falling edge register
    ////////////////////
    // half a cycle of setup for the host sampling on the next rising edge
    always_ff @(negedge jtag_tck_i or negedge jtag_trstn_i) begin
        if (!jtag_trstn_i) begin
            jtag_tdo_o <= 1'b0;
        end else begin
            jtag_tdo_o <= tdo_d;
        end
    end

    // driven only while shifting
    assign jtag_tdo_enable_o = shift_any_i;

endmodule

// ==== jtag_tap.f ====
+incdir+hw
hw/jtag_tap_pkg.sv
hw/tap_fsm.sv
hw/instr_reg.sv
hw/data_regs.sv
hw/tdo_out.sv
hw/jtag_tap_top.sv
verification/tb_jtag_tap.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the jtag tap testbench with verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_jtag_tap -f jtag_tap.f -o tb_jtag_tap \
    && ./obj_dir/tb_jtag_tap | tee /dev/stderr | grep -qx "Everything OK" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== verification/tb_jtag_tap.sv ====
// testbench for the jtag tap that scans its registers over tms/tdi and checks tdo and the dtmcs pulses
`timescale 1ns/1ps

`include "jtag_tap_defines.svh"

module tb_jtag_tap;
    import jtag_tap_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int WATCHDOG_NS = (NUM_TESTS * 200 + 100) * 4;

    logic           jtag_tck_i;
    logic           jtag_trstn_i;
    logic           jtag_tms_i;
    logic           jtag_tdi_i;
    dtmcs_version_t dtmcs_version_i;
    dtmcs_abits_t   dtmcs_abits_i;
    dtmcs_dmistat_t dtmcs_dmistat_i;
    dtmcs_idle_t    dtmcs_idle_i;
    logic           jtag_tdo_o;
    logic           jtag_tdo_enable_o;
    logic           dtmcs_dmireset_o;
    logic           dtmcs_dmihardreset_o;

    // expected per-cycle outputs compared on every falling edge
    logic        monitor_on = 1'b0;
    logic        exp_enable = 1'b0;
    logic        exp_dmireset = 1'b0;
    logic        exp_hardreset = 1'b0;
    ir_t         cur_instr = `JTAG_INSTR_BYPASS0;
    int          error_count = 0;
    int          errors_before = 0;
    int          tests_failed = 0;
    int          test_num = 0;
    int          k;
    int unsigned rnd;
    logic        tdo_bit;
    dr_word_t    din;
    dr_word_t    dout;
    ir_t         ir_out;

    jtag_tap_top dut (.*);

    always #2 jtag_tck_i = ~jtag_tck_i;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        if (error_count == errors_before) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     error_count - errors_before);
            tests_failed++;
        end
        errors_before = error_count;
    endtask

    // captured word as the host should see it lsb first
    function automatic dr_word_t expected_word(input ir_t instr, input dr_word_t data_in);
        dr_word_t word;
        word = '0;
        case (instr)
            `JTAG_INSTR_IDCODE: begin
                word[0]     = 1'b1;
                word[11:1]  = `JTAG_IDCODE_MANUF;
                word[27:12] = `JTAG_IDCODE_PART;
                word[31:28] = `JTAG_IDCODE_VERSION;
            end
            `JTAG_INSTR_DTMCS: begin
                word[3:0]   = dtmcs_version_i;
                word[9:4]   = dtmcs_abits_i;
                word[11:10] = dtmcs_dmistat_i;
                word[14:12] = dtmcs_idle_i;
            end
            // for bypass tdi comes back one bit late behind the captured 0
            default: word = {data_in[30:0], 1'b0};
        endcase
        return word;
    endfunction

    // one tck period entered and left 0.5 ns after a rising edge
    task automatic clock_cycle(input logic tms, input logic tdi, input logic shifting,
                               output logic tdo_sample);
        exp_enable = shifting;
        jtag_tms_i = tms;
        jtag_tdi_i = tdi;
        @(negedge jtag_tck_i);
        #1;
        tdo_sample = jtag_tdo_o;
        @(posedge jtag_tck_i);
        #0.5;
    endtask

    // run-test/idle to run-test/idle through shift-ir
    task automatic ir_scan(input ir_t instr, output ir_t captured);
        logic bit_out;
        int i;
        captured = '0;
        clock_cycle(1'b1, 1'b0, 1'b0, bit_out);
        clock_cycle(1'b1, 1'b0, 1'b0, bit_out);
        clock_cycle(1'b0, 1'b0, 1'b0, bit_out);
        clock_cycle(1'b0, 1'b0, 1'b0, bit_out);
        for (i = 0; i < `JTAG_IR_WIDTH; i++) begin
            clock_cycle(i == `JTAG_IR_WIDTH - 1, instr[i], 1'b1, bit_out);
            captured[i] = bit_out;
        end
        clock_cycle(1'b1, 1'b0, 1'b0, bit_out);
        clock_cycle(1'b0, 1'b0, 1'b0, bit_out);
        cur_instr = instr;
    endtask

    // run-test/idle to run-test/idle through shift-dr
    task automatic dr_scan(input dr_word_t data_in, input int len, output dr_word_t captured);
        logic bit_out;
        int i;
        captured = '0;
        clock_cycle(1'b1, 1'b0, 1'b0, bit_out);
        clock_cycle(1'b0, 1'b0, 1'b0, bit_out);
        clock_cycle(1'b0, 1'b0, 1'b0, bit_out);
        for (i = 0; i < len; i++) begin
            clock_cycle(i == len - 1, data_in[i], 1'b1, bit_out);
            captured[i] = bit_out;
        end
        clock_cycle(1'b1, 1'b0, 1'b0, bit_out);
        // update-dr is the only cycle a reset pulse may show
        exp_dmireset  = (cur_instr == `JTAG_INSTR_DTMCS) && data_in[`JTAG_DTMCS_DMIRESET_BIT];
        exp_hardreset = (cur_instr == `JTAG_INSTR_DTMCS) && data_in[`JTAG_DTMCS_HARDRESET_BIT];
        clock_cycle(1'b0, 1'b0, 1'b0, bit_out);
        exp_dmireset  = 1'b0;
        exp_hardreset = 1'b0;
    endtask

    always @(negedge jtag_tck_i) begin
        if (monitor_on) begin
            check_value("jtag_tdo_enable_o", 32'(exp_enable), 32'(jtag_tdo_enable_o));
            check_value("dtmcs_dmireset_o", 32'(exp_dmireset), 32'(dtmcs_dmireset_o));
            check_value("dtmcs_dmihardreset_o", 32'(exp_hardreset), 32'(dtmcs_dmihardreset_o));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the scans did not finish", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin
        jtag_tck_i      = 1'b0;
        jtag_trstn_i    = 1'b0;
        jtag_tms_i      = 1'b1;
        jtag_tdi_i      = 1'b0;
        dtmcs_version_i = '0;
        dtmcs_abits_i   = '0;
        dtmcs_dmistat_i = '0;
        dtmcs_idle_i    = '0;
        rnd = $urandom(62167);
        repeat (3) @(posedge jtag_tck_i);
        #0.5;
        monitor_on = 1'b1;
        jtag_trstn_i = 1'b1;
        clock_cycle(1'b0, 1'b0, 1'b0, tdo_bit);

        ////////////////////
        // bypass after reset and ir capture
        ////////////////////
        rnd = $urandom();
        din = {16'h0, rnd[15:0]};
        dr_scan(din, 16, dout);
        check_value("jtag_tdo_o", expected_word(cur_instr, din) & 32'hffff, dout);
        report_test("bypass after reset");
        ir_scan(`JTAG_INSTR_IDCODE, ir_out);
        check_value("jtag_tdo_o", 32'(`JTAG_IR_CAPTURE), 32'(ir_out));
        report_test("ir capture and tdo enable");

        din = $urandom();
        dr_scan(din, 32, dout);
        check_value("jtag_tdo_o", expected_word(cur_instr, din), dout);
        report_test("idcode");

        ////////////////////
        // dtmcs capture and reset pulses
        ////////////////////
        ir_scan(`JTAG_INSTR_DTMCS, ir_out);
        rnd = $urandom();
        dtmcs_version_i = rnd[3:0];
        dtmcs_abits_i   = rnd[9:4];
        dtmcs_dmistat_i = rnd[11:10];
        dtmcs_idle_i    = rnd[14:12];
        din = $urandom() & 32'hfffc_ffff;
        dr_scan(din, 32, dout);
        check_value("jtag_tdo_o", expected_word(cur_instr, din), dout);
        report_test("dtmcs capture");
        // scans that set dmireset, dmihardreset and neither in turn
        for (k = 0; k < 3; k++) begin
            din = $urandom() & 32'hfffc_ffff;
            din[`JTAG_DTMCS_DMIRESET_BIT]  = (k == 0);
            din[`JTAG_DTMCS_HARDRESET_BIT] = (k == 1);
            dr_scan(din, 32, dout);
            check_value("jtag_tdo_o", expected_word(cur_instr, din), dout);
        end
        report_test("dtmcs reset pulses");

        ////////////////////
        // second bypass code and a tms reset that keeps the instruction
        ////////////////////
        ir_scan(`JTAG_INSTR_BYPASS1, ir_out);
        rnd = $urandom();
        din = {16'h0, rnd[15:0]};
        dr_scan(din, 16, dout);
        check_value("jtag_tdo_o", expected_word(cur_instr, din) & 32'hffff, dout);
        ir_scan(`JTAG_INSTR_IDCODE, ir_out);
        clock_cycle(1'b1, 1'b0, 1'b0, tdo_bit);
        clock_cycle(1'b0, 1'b0, 1'b0, tdo_bit);
        clock_cycle(1'b0, 1'b0, 1'b0, tdo_bit);
        // five tms high cycles from shift-dr to test-logic-reset
        clock_cycle(1'b1, 1'b0, 1'b1, tdo_bit);
        repeat (4) clock_cycle(1'b1, 1'b0, 1'b0, tdo_bit);
        clock_cycle(1'b0, 1'b0, 1'b0, tdo_bit);
        din = $urandom();
        dr_scan(din, 32, dout);
        check_value("jtag_tdo_o", expected_word(cur_instr, din), dout);
        report_test("bypass 0x1f and tms reset");

        $display("tests run %0d, failed %0d, check errors %0d",
                 test_num, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
